// ==== hw/xif_dispatch_ctrl.sv ====
/*
  Dispatch controller of the offload unit.
  Gates the issue request, generates the offload id, remembers whether
  the instruction in ID was already offloaded, maps the privilege level
  to the issue mode and decides stall and illegal instruction. Drives
  the claim toward the scoreboard and the announce toward the memory
  tracker. All outputs are combinational on inputs and state.
*/

`timescale 1ns/10ps

module xif_dispatch_ctrl
  import xif_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,

  // pipeline control
  input  logic             instr_valid_i,
  input  logic             offload_dec_i,
  input  logic             branch_or_jump_i,
  input  logic             data_req_dec_i,
  input  logic             id_ready_i,
  input  reg_addr_t        waddr_id_i,
  input  logic [NumRs-1:0] regs_used_i,
  input  rs_addr_vec_t     rs_addr_i,
  input  priv_lvl_e        priv_lvl_i,

  // issue handshake and response
  input  logic             issue_ready_i,
  input  logic             issue_accept_i,
  input  logic             issue_writeback_i,
  input  logic             issue_loadstore_i,

  // scoreboard and memory tracker
  output logic             claim_o,
  output reg_addr_t        claim_rd_o,
  output logic             announce_o,
  input  logic             mem_outstanding_i,
  input  logic             mem_valid_i,

  xif_hazard_if.ctrl       hazard,

  output logic [IdW-1:0]   id_o,
  output logic             issue_valid_o,
  output xif_mode_t        mode_o,
  output logic             stall_o,
  output logic             illegal_o
);

  logic [IdW-1:0] id_q;
  logic           offloaded_q;
  logic           transfer;

  // stall terms
  logic           stall_dep;
  logic           stall_mem;
  logic           stall_branch;
  logic           stall_not_ready;
  logic           stall_mem_req;

  ////////////////////////////////////////////////////////////
  // issue gating
  ////////////////////////////////////////////////////////////

  // branches and jumps never go out, and an instr goes out once only
  assign issue_valid_o = instr_valid_i & offload_dec_i & ~branch_or_jump_i & ~offloaded_q;
  assign transfer      = issue_valid_o & issue_ready_i;
  assign id_o          = id_q;

  // operand check request
  assign hazard.rs_addr   = rs_addr_i;
  assign hazard.regs_used = regs_used_i;

  // responses only count in the transfer cycle
  assign illegal_o  = transfer & ~issue_accept_i;
  assign claim_o    = transfer & issue_writeback_i;
  assign claim_rd_o = waddr_id_i;
  assign announce_o = transfer & issue_loadstore_i;

  ////////////////////////////////////////////////////////////
  // stall decision
  ////////////////////////////////////////////////////////////

  // no point stalling on operands of a rejected instr
  assign stall_dep       = hazard.dep & ~illegal_o;
  assign stall_mem       = mem_outstanding_i & data_req_dec_i;
  assign stall_branch    = offload_dec_i & branch_or_jump_i;
  assign stall_not_ready = issue_valid_o & ~issue_ready_i;
  // coprocessor owns the lsu this cycle
  assign stall_mem_req   = mem_valid_i & ~transfer;

  assign stall_o = stall_dep | stall_mem | stall_branch | stall_not_ready | stall_mem_req;

  // privilege level to issue mode
  always_comb begin
    case (priv_lvl_i)
      PRIV_LVL_M: mode_o = ModeMachine;
      PRIV_LVL_H: mode_o = ModeHypervisor;
      PRIV_LVL_S: mode_o = ModeSupervisor;
      PRIV_LVL_U: mode_o = ModeUser;
      default:    mode_o = ModeMachine;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // id and offloaded flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q        <= '0;
      offloaded_q <= 1'b0;
    end else begin
      if (transfer) begin
        id_q <= id_q + 1'b1;
      end
      // ID moving on frees the slot, even in a transfer cycle
      if (id_ready_i) begin
        offloaded_q <= 1'b0;
      end else if (transfer) begin
        offloaded_q <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/xif_hazard_if.sv ====
/*
  Hazard bundle between the dispatch controller and the operand checker.
  The controller presents the source addresses and their use bits, the
  checker answers with per-source readiness, forwarding and the
  dependency flag.
*/

`timescale 1ns/10ps

interface xif_hazard_if
  import xif_pkg::*;
();

  // request side, from the controller
  rs_addr_vec_t     rs_addr;
  logic [NumRs-1:0] regs_used;

  // answer side, from the operand checker
  logic [NumRs-1:0] rs_valid;
  logic [NumRs-1:0] ex_fwd;
  logic [NumRs-1:0] wb_fwd;
  // some used source still owed by the coprocessor
  logic             dep;

  modport ctrl (
    output rs_addr,
    output regs_used,
    input  rs_valid,
    input  ex_fwd,
    input  wb_fwd,
    input  dep
  );

  modport check (
    input  rs_addr,
    input  regs_used,
    output rs_valid,
    output ex_fwd,
    output wb_fwd,
    output dep
  );

endinterface

// ==== hw/xif_mem_tracker.sv ====
/*
  Tracks coprocessor memory transactions that were announced at issue
  but have not started on the memory request channel yet. The
  outstanding flag lets the controller hold back core data requests.
*/

`timescale 1ns/10ps

module xif_mem_tracker #(
  parameter int unsigned MemCntW = 2
) (
  input  logic clk_i,
  input  logic rst_ni,

  // loadstore transfer accepted
  input  logic announce_i,
  // memory request from the coprocessor
  input  logic mem_valid_i,

  output logic outstanding_o
);

  logic [MemCntW-1:0] cnt_q;

  // both in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (announce_i && !mem_valid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (mem_valid_i && !announce_i && (cnt_q != '0)) begin
      // unannounced request leaves the count at zero
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign outstanding_o = (cnt_q != '0);

endmodule

// ==== hw/xif_offload_unit.sv ====
/*
  Top level of the core-side offload unit.
  Plain ports toward the pipeline and the coprocessor extension
  interface. Instantiates the dispatch controller, scoreboard, operand
  checker and memory tracker, and wires the echo channels.
*/

`timescale 1ns/10ps

module xif_offload_unit
  import xif_pkg::*;
#(
  parameter int unsigned MemCntW = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  // issue channel
  output logic               x_issue_valid_o,
  input  logic               x_issue_ready_i,
  output logic [IdW-1:0]     x_issue_id_o,
  output logic [NumRs-1:0]   x_issue_rs_valid_o,
  output xif_mode_t          x_issue_mode_o,
  input  logic               x_issue_accept_i,
  input  logic               x_issue_writeback_i,
  input  logic               x_issue_loadstore_i,

  // commit channel
  output logic               x_commit_valid_o,
  output logic [IdW-1:0]     x_commit_id_o,

  // memory request and memory result
  input  logic               x_mem_valid_i,
  output logic               x_mem_ready_o,
  output logic               x_mem_data_req_o,
  input  logic               x_mem_instr_wb_i,
  output logic               x_mem_result_valid_o,

  // result channel
  input  logic               x_result_valid_i,
  input  reg_addr_t          x_result_rd_i,
  input  logic               x_result_we_i,

  // pipeline
  input  logic               instr_valid_i,
  input  logic               offload_dec_i,
  input  logic               branch_or_jump_i,
  input  logic               data_req_dec_i,
  input  logic               id_ready_i,
  input  logic               ex_valid_i,
  input  reg_addr_t          waddr_id_i,
  input  reg_addr_t          waddr_ex_i,
  input  logic               we_ex_i,
  input  reg_addr_t          waddr_wb_i,
  input  logic               we_wb_i,
  input  reg_addr_t          mem_waddr_ex_i,
  input  logic               mem_we_ex_i,
  input  logic [NumRs-1:0]   regs_used_i,
  input  rs_addr_vec_t       rs_addr_i,
  input  priv_lvl_e          priv_lvl_i,
  output logic [NumRs-1:0]   x_ex_fwd_o,
  output logic [NumRs-1:0]   x_wb_fwd_o,
  output logic               x_stall_o,
  output logic               x_illegal_insn_o
);

  logic               issue_valid;
  logic [IdW-1:0]     issue_id;
  logic               claim;
  reg_addr_t          claim_rd;
  logic               announce;
  logic               mem_outstanding;
  logic [NumRegs-1:0] pending;

  xif_hazard_if hazard ();

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  xif_dispatch_ctrl i_dispatch_ctrl (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .offload_dec_i,
    .branch_or_jump_i,
    .data_req_dec_i,
    .id_ready_i,
    .waddr_id_i,
    .regs_used_i,
    .rs_addr_i,
    .priv_lvl_i,
    .issue_ready_i     (x_issue_ready_i),
    .issue_accept_i    (x_issue_accept_i),
    .issue_writeback_i (x_issue_writeback_i),
    .issue_loadstore_i (x_issue_loadstore_i),
    .claim_o           (claim),
    .claim_rd_o        (claim_rd),
    .announce_o        (announce),
    .mem_outstanding_i (mem_outstanding),
    .mem_valid_i       (x_mem_valid_i),
    .hazard            (hazard.ctrl),
    .id_o              (issue_id),
    .issue_valid_o     (issue_valid),
    .mode_o            (x_issue_mode_o),
    .stall_o           (x_stall_o),
    .illegal_o         (x_illegal_insn_o)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  xif_scoreboard i_scoreboard (
    .clk_i,
    .rst_ni,
    .claim_i        (claim),
    .claim_rd_i     (claim_rd),
    .result_valid_i (x_result_valid_i),
    .result_we_i    (x_result_we_i),
    .result_rd_i    (x_result_rd_i),
    .pending_o      (pending)
  );

  xif_operand_check i_operand_check (
    .hazard         (hazard.check),
    .pending_i      (pending),
    .waddr_ex_i,
    .we_ex_i,
    .waddr_wb_i,
    .we_wb_i,
    .ex_valid_i,
    .mem_waddr_ex_i,
    .mem_we_ex_i
  );

  xif_mem_tracker #(
    .MemCntW (MemCntW)
  ) i_mem_tracker (
    .clk_i,
    .rst_ni,
    .announce_i    (announce),
    .mem_valid_i   (x_mem_valid_i),
    .outstanding_o (mem_outstanding)
  );

  // issue and commit share valid and id
  assign x_issue_valid_o    = issue_valid;
  assign x_issue_id_o       = issue_id;
  assign x_commit_valid_o   = issue_valid;
  assign x_commit_id_o      = issue_id;
  assign x_issue_rs_valid_o = hazard.rs_valid;
  assign x_ex_fwd_o         = hazard.ex_fwd;
  assign x_wb_fwd_o         = hazard.wb_fwd;

  // memory requests taken in the same cycle
  assign x_mem_ready_o        = x_mem_valid_i;
  assign x_mem_data_req_o     = x_mem_valid_i;
  assign x_mem_result_valid_o = x_mem_instr_wb_i;

endmodule

// ==== hw/xif_operand_check.sv ====
/*
  Operand checker of the offload unit.
  For every source operand works out forwarding from EX and WB, whether
  the value can be sent with the issue request, and whether a used
  source is still pending in the scoreboard. Purely combinational,
  answers the controller through the hazard bundle.
*/

`timescale 1ns/10ps

module xif_operand_check
  import xif_pkg::*;
(
  xif_hazard_if.check        hazard,

  // pending writebacks from the scoreboard
  input  logic [NumRegs-1:0] pending_i,

  // pipeline writeback ports
  input  reg_addr_t          waddr_ex_i,
  input  logic               we_ex_i,
  input  reg_addr_t          waddr_wb_i,
  input  logic               we_wb_i,
  input  logic               ex_valid_i,

  // load sitting in EX, its data is not there yet
  input  reg_addr_t          mem_waddr_ex_i,
  input  logic               mem_we_ex_i
);

  logic [NumRs-1:0] src_pending;
  logic [NumRs-1:0] ex_fwd;
  logic [NumRs-1:0] wb_fwd;

  ////////////////////////////////////////////////////////////
  // per source
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumRs; i++) begin : g_src
    reg_addr_t rs;
    logic      load_hit;

    assign rs = hazard.rs_addr[i];

    assign src_pending[i] = pending_i[rs];

    // both forwarding paths gated by EX valid
    assign ex_fwd[i] = (rs == waddr_ex_i) & we_ex_i & ex_valid_i;
    assign wb_fwd[i] = (rs == waddr_wb_i) & we_wb_i & ex_valid_i;

    assign load_hit = (rs == mem_waddr_ex_i) & mem_we_ex_i;

    // forwarded value overrides the pending bit, a load in EX never does
    assign hazard.rs_valid[i] = (~src_pending[i] | ex_fwd[i] | wb_fwd[i]) & ~load_hit;
  end

  assign hazard.ex_fwd = ex_fwd;
  assign hazard.wb_fwd = wb_fwd;

  // only sources the instr really reads count
  assign hazard.dep = |(hazard.regs_used & src_pending);

endmodule

// ==== hw/xif_pkg.sv ====
/*
  Shared widths and types for the core-side coprocessor offload unit.
  Imported by every design file that needs register address widths,
  the offload id width, the privilege level or the issue mode encoding.
*/

package xif_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // source operands a coprocessor instruction may read
  localparam int unsigned NumRs    = 3;
  // integer register file
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned NumRegs  = 32;
  // offload id, wraps after 16 transfers
  localparam int unsigned IdW      = 4;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [RegAddrW-1:0] reg_addr_t;

  // one address per source, rs1 in slot 0
  typedef logic [NumRs-1:0][RegAddrW-1:0] rs_addr_vec_t;

  // core privilege level, standard RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mode field sent along with an issue request
  typedef logic [1:0] xif_mode_t;

  localparam xif_mode_t ModeMachine    = 2'd3;
  localparam xif_mode_t ModeHypervisor = 2'd2;
  localparam xif_mode_t ModeSupervisor = 2'd1;
  localparam xif_mode_t ModeUser       = 2'd0;

endpackage

// ==== hw/xif_scoreboard.sv ====
/*
  Pending writeback bitmap over the integer register file.
  A claim from the dispatch controller marks the destination of an
  offloaded instr, a coprocessor result with write enable clears it.
  The bitmap feeds the operand checker.
*/

`timescale 1ns/10ps

module xif_scoreboard
  import xif_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  // new writeback owed by the coprocessor
  input  logic               claim_i,
  input  reg_addr_t          claim_rd_i,

  // result channel
  input  logic               result_valid_i,
  input  logic               result_we_i,
  input  reg_addr_t          result_rd_i,

  output logic [NumRegs-1:0] pending_o
);

  logic [NumRegs-1:0] pending_q;
  logic [NumRegs-1:0] pending_d;

  // claim applied last so it wins on the same register
  // the newer instr still owes its write
  always_comb begin
    pending_d = pending_q;
    if (result_valid_i && result_we_i) begin
      pending_d[result_rd_i] = 1'b0;
    end
    if (claim_i) begin
      pending_d[claim_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign pending_o = pending_q;

endmodule

// ==== project.f ====
hw/xif_pkg.sv
hw/xif_hazard_if.sv
hw/xif_dispatch_ctrl.sv
hw/xif_scoreboard.sv
hw/xif_operand_check.sv
hw/xif_mem_tracker.sv
hw/xif_offload_unit.sv
tests/xif_offload_assertions.sv
tests/tb_xif_offload_unit.sv

// ==== tests/tb_xif_offload_unit.sv ====
/*
  Testbench for the offload unit. Plays pipeline, coprocessor and memory
  from per-cycle vectors in tests/xif_offload_cases.txt, drives them on
  the falling edge and checks the outputs just before the next rising
  edge. One report line per test, counts at the end.
*/

`timescale 1ns/10ps

module tb_xif_offload_unit
  import xif_pkg::*;
();

  logic clk, rst_n;
  // pipeline side
  logic instr_valid, offload_dec, branch_or_jump, data_req_dec, id_ready, ex_valid;
  reg_addr_t waddr_id, waddr_ex, waddr_wb, mem_waddr_ex, result_rd;
  logic we_ex, we_wb, mem_we_ex;
  logic [NumRs-1:0] regs_used;
  rs_addr_vec_t rs_addr;
  priv_lvl_e priv_lvl;
  // coprocessor and memory side
  logic issue_ready, issue_accept, issue_writeback, issue_loadstore;
  logic mem_valid, mem_instr_wb, result_valid, result_we;
  // DUT outputs
  logic issue_valid, commit_valid, mem_ready, mem_data_req, mem_result_valid;
  logic stall, illegal;
  logic [IdW-1:0] issue_id, commit_id;
  logic [NumRs-1:0] rs_valid, ex_fwd, wb_fwd;
  xif_mode_t mode;
  // expected values from the vector file
  logic exp_valid, exp_stall, exp_illegal;
  logic [IdW-1:0] exp_id;
  logic [NumRs-1:0] exp_rs_valid, exp_ex_fwd, exp_wb_fwd;
  xif_mode_t exp_mode;

  string vectors[$];
  int num_vec = 0;
  bit loaded = 1'b0;
  int checks = 0;
  int errors = 0;
  int assert_fails = 0;
  int cur_test = 0;
  int test_vecs = 0;
  int test_err_base = 0;

  xif_offload_unit #(.MemCntW(2)) i_xif_offload_unit (
    .clk_i (clk), .rst_ni (rst_n),
    .x_issue_valid_o (issue_valid), .x_issue_ready_i (issue_ready),
    .x_issue_id_o (issue_id), .x_issue_rs_valid_o (rs_valid), .x_issue_mode_o (mode),
    .x_issue_accept_i (issue_accept), .x_issue_writeback_i (issue_writeback),
    .x_issue_loadstore_i (issue_loadstore),
    .x_commit_valid_o (commit_valid), .x_commit_id_o (commit_id),
    .x_mem_valid_i (mem_valid), .x_mem_ready_o (mem_ready), .x_mem_data_req_o (mem_data_req),
    .x_mem_instr_wb_i (mem_instr_wb), .x_mem_result_valid_o (mem_result_valid),
    .x_result_valid_i (result_valid), .x_result_rd_i (result_rd), .x_result_we_i (result_we),
    .instr_valid_i (instr_valid), .offload_dec_i (offload_dec),
    .branch_or_jump_i (branch_or_jump), .data_req_dec_i (data_req_dec),
    .id_ready_i (id_ready), .ex_valid_i (ex_valid), .waddr_id_i (waddr_id),
    .waddr_ex_i (waddr_ex), .we_ex_i (we_ex), .waddr_wb_i (waddr_wb), .we_wb_i (we_wb),
    .mem_waddr_ex_i (mem_waddr_ex), .mem_we_ex_i (mem_we_ex), .regs_used_i (regs_used),
    .rs_addr_i (rs_addr), .priv_lvl_i (priv_lvl),
    .x_ex_fwd_o (ex_fwd), .x_wb_fwd_o (wb_fwd), .x_stall_o (stall),
    .x_illegal_insn_o (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // vector count plus 10 cycles of slack
  initial begin
    wait (loaded);
    #((num_vec + 10) * 20);
    $display("watchdog expired, vectors did not finish within %0d cycles", num_vec + 10);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // vector file
  ////////////////////////////////////////////////////////////

  task automatic load_vectors(output bit ok);
    int fd;
    int code;
    string line;
    ok = 1'b0;
    fd = $fopen("tests/xif_offload_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        // blank and comment lines skipped
        if (code > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
          vectors.push_back(line);
        end
      end
      $fclose(fd);
      ok = (vectors.size() > 0);
    end
  endtask

  // parse one line, drive inputs, latch expected outputs
  task automatic apply_vector(input string line, output int test_no, output bit ok);
    int n;
    logic [5:0] pipe;
    logic [3:0] resp;
    logic [1:0] mem;
    logic [1:0] prv;
    reg_addr_t rs1, rs2, rs3;
    n = $sscanf(line,
      "%d %b %h %h %b %h %b %h %b %b %h %h %h %h %b %b %b %h %b %b %h %b %h %b %b %b %b",
      test_no, pipe, waddr_id, waddr_ex, we_ex, waddr_wb, we_wb, mem_waddr_ex, mem_we_ex,
      regs_used, rs1, rs2, rs3, prv, resp, mem, result_valid, result_rd, result_we,
      exp_valid, exp_id, exp_rs_valid, exp_mode, exp_ex_fwd, exp_wb_fwd, exp_stall,
      exp_illegal);
    ok = (n == 27);
    {instr_valid, offload_dec, branch_or_jump, data_req_dec, id_ready, ex_valid} = pipe;
    {issue_ready, issue_accept, issue_writeback, issue_loadstore} = resp;
    {mem_valid, mem_instr_wb} = mem;
    rs_addr[0] = rs1;
    rs_addr[1] = rs2;
    rs_addr[2] = rs3;
    priv_lvl = priv_lvl_e'(prv);
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      $display("ERROR test %0d %s expected 0x%0h actual 0x%0h", cur_test, name, expected,
               actual);
      errors++;
    end
  endtask

  task automatic check_outputs();
    check_value("x_issue_valid_o", issue_valid, exp_valid);
    check_value("x_issue_id_o", issue_id, exp_id);
    check_value("x_issue_rs_valid_o", rs_valid, exp_rs_valid);
    check_value("x_issue_mode_o", mode, exp_mode);
    check_value("x_ex_fwd_o", ex_fwd, exp_ex_fwd);
    check_value("x_wb_fwd_o", wb_fwd, exp_wb_fwd);
    check_value("x_stall_o", stall, exp_stall);
    check_value("x_illegal_insn_o", illegal, exp_illegal);
    // commit mirrors issue and the memory channels echo their inputs
    check_value("x_commit_valid_o", commit_valid, exp_valid);
    check_value("x_commit_id_o", commit_id, exp_id);
    check_value("x_mem_ready_o", mem_ready, mem_valid);
    check_value("x_mem_data_req_o", mem_data_req, mem_valid);
    check_value("x_mem_result_valid_o", mem_result_valid, mem_instr_wb);
  endtask

  task automatic report_test();
    $display("test %0d finished, %0d cycles, %0d errors", cur_test, test_vecs,
             errors - test_err_base);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bit ok;
    int test_no;
    rst_n = 1'b0;
    {instr_valid, offload_dec, branch_or_jump, data_req_dec, id_ready, ex_valid} = '0;
    {waddr_id, waddr_ex, waddr_wb, mem_waddr_ex, result_rd} = '0;
    {we_ex, we_wb, mem_we_ex, regs_used, rs_addr} = '0;
    {issue_ready, issue_accept, issue_writeback, issue_loadstore} = '0;
    {mem_valid, mem_instr_wb, result_valid, result_we} = '0;
    priv_lvl = PRIV_LVL_M;
    load_vectors(ok);
    if (!ok) begin
      $display("no vectors could be read from tests/xif_offload_cases.txt");
      $display("Checks failed");
      $finish;
    end else begin
      num_vec = vectors.size();
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      foreach (vectors[i]) begin
        @(negedge clk);
        apply_vector(vectors[i], test_no, ok);
        if (test_no != cur_test) begin
          if (cur_test != 0) begin
            report_test();
          end
          cur_test = test_no;
          test_vecs = 0;
          test_err_base = errors;
        end
        test_vecs++;
        // sample 1 ns before the rising edge
        #9;
        assert (ok) else begin
          $display("vector line %0d could not be parsed", i + 1);
          errors++;
        end
        if (ok) begin
          check_outputs();
        end
      end
      report_test();
      // bound controller assertions
      assert_fails = i_xif_offload_unit.i_dispatch_ctrl.i_offload_assertions.fail_count;
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
               assert_fails);
      if (errors == 0 && assert_fails == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// ==== tests/xif_offload_assertions.sv ====
/*
  Concurrent checks on the dispatch controller, bound into every
  instance of it. Covers the illegal flag, back-pressure on the issue
  channel and the offload id between transfers.
*/

`timescale 1ns/10ps

module xif_offload_assertions
  import xif_pkg::*;
(
  input logic           clk_i,
  input logic           rst_ni,
  input logic           issue_valid_i,
  input logic           issue_ready_i,
  input logic           illegal_i,
  input logic           stall_i,
  input logic [IdW-1:0] id_i
);

  logic transfer;

  // failed assertions so far
  int unsigned fail_count = 0;

  // handshake on the issue channel
  assign transfer = issue_valid_i & issue_ready_i;

  // rejection only means something on a handshake
  illegal_in_transfer: assert property (
    @(posedge clk_i) disable iff (!rst_ni) illegal_i |-> transfer
  ) else begin
    $error("illegal flag raised outside a transfer cycle");
    fail_count++;
  end

  // coprocessor not ready so the pipeline has to wait
  stall_on_backpressure: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (issue_valid_i && !issue_ready_i) |-> stall_i
  ) else begin
    $error("issue valid without ready did not stall");
    fail_count++;
  end

  // id moves on handshakes only
  id_holds_without_transfer: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !transfer |=> $stable(id_i)
  ) else begin
    $error("offload id changed without a transfer");
    fail_count++;
  end

endmodule

bind xif_dispatch_ctrl xif_offload_assertions i_offload_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_valid_i (issue_valid_o),
  .issue_ready_i (issue_ready_i),
  .illegal_i     (illegal_o),
  .stall_i       (stall_o),
  .id_i          (id_o)
);

// ==== tests/xif_offload_cases.txt ====
// test pipe[iv od bj dr ir ev] wid wex wee wwb wwe mwa mwe used rs1 rs2 rs3 prv resp[rdy acc wb ls]
// mem[mv wb] rv rrd rwe, expected ival id rs_valid mode ex_fwd wb_fwd stall ill, vectors rs3..rs1
1 000000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 0 111 3 000 000 0 0
1 111000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 0 111 3 000 000 1 0
1 110000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  1 0 111 3 000 000 1 0
1 110000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  1 0 111 3 000 000 1 0
1 110010 00 00 0 00 0 00 0 000 00 00 00 3 1100 00 0 00 0  1 0 111 3 000 000 0 0
1 110000 00 00 0 00 0 00 0 000 00 00 00 3 1100 00 0 00 0  1 1 111 3 000 000 0 0
1 110000 00 00 0 00 0 00 0 000 00 00 00 3 1100 00 0 00 0  0 2 111 3 000 000 0 0
1 000010 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 2 111 3 000 000 0 0
1 010000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 2 111 3 000 000 0 0
2 110010 05 00 0 00 0 00 0 000 00 00 00 3 1110 00 0 00 0  1 2 111 3 000 000 0 0
2 100000 00 00 0 00 0 00 0 001 05 00 00 3 0000 00 0 00 0  0 3 110 3 000 000 1 0
2 100000 00 00 0 00 0 00 0 001 05 00 00 3 0000 00 1 05 1  0 3 110 3 000 000 1 0
2 100000 00 00 0 00 0 00 0 001 05 00 00 3 0000 00 0 00 0  0 3 111 3 000 000 0 0
2 110010 07 00 0 00 0 00 0 000 00 00 00 3 1110 00 1 07 1  1 3 111 3 000 000 0 0
2 100000 00 00 0 00 0 00 0 001 07 00 00 3 0000 00 0 00 0  0 4 110 3 000 000 1 0
3 100001 00 07 1 00 0 00 0 000 07 00 00 3 0000 00 0 00 0  0 4 111 3 001 000 0 0
3 100001 00 00 0 07 1 00 0 000 07 00 00 3 0000 00 0 00 0  0 4 111 3 000 001 0 0
3 100001 00 07 1 00 0 07 1 000 07 00 00 3 0000 00 0 00 0  0 4 110 3 001 000 0 0
3 100000 00 07 1 00 0 00 0 000 07 00 00 3 0000 00 0 00 0  0 4 110 3 000 000 0 0
3 000000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 1 07 1  0 4 111 3 000 000 0 0
4 110010 00 00 0 00 0 00 0 000 00 00 00 3 1000 00 0 00 0  1 4 111 3 000 000 0 1
4 110010 09 00 0 00 0 00 0 000 00 00 00 3 1110 00 0 00 0  1 5 111 3 000 000 0 0
4 110010 00 00 0 00 0 00 0 001 09 00 00 3 1000 00 0 00 0  1 6 110 3 000 000 0 1
4 000000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 1 09 1  0 7 111 3 000 000 0 0
5 110010 00 00 0 00 0 00 0 000 00 00 00 3 1101 00 0 00 0  1 7 111 3 000 000 0 0
5 100100 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 8 111 3 000 000 1 0
5 100100 00 00 0 00 0 00 0 000 00 00 00 3 0000 10 0 00 0  0 8 111 3 000 000 1 0
5 100100 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 8 111 3 000 000 0 0
5 110010 00 00 0 00 0 00 0 000 00 00 00 3 1100 10 0 00 0  1 8 111 3 000 000 0 0
5 000000 00 00 0 00 0 00 0 000 00 00 00 3 0000 01 0 00 0  0 9 111 3 000 000 0 0
6 110000 00 00 0 00 0 00 0 000 00 00 00 0 0000 00 0 00 0  1 9 111 0 000 000 1 0
6 110000 00 00 0 00 0 00 0 000 00 00 00 1 0000 00 0 00 0  1 9 111 1 000 000 1 0
6 110000 00 00 0 00 0 00 0 000 00 00 00 2 0000 00 0 00 0  1 9 111 2 000 000 1 0
6 110000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  1 9 111 3 000 000 1 0
6 110010 00 00 0 00 0 00 0 000 00 00 00 3 1100 00 0 00 0  1 9 111 3 000 000 0 0
6 000000 00 00 0 00 0 00 0 000 00 00 00 3 0000 00 0 00 0  0 a 111 3 000 000 0 0
